// ==== dv/vga_ref.svh ====
`ifndef VGA_REF_SVH
`define VGA_REF_SVH

// expected raster geometry of the chip under test
int ref_w;
int ref_h;
int ref_hs_sta;
int ref_hs_end;
int ref_ha_sta;
int ref_vs_sta;
int ref_vs_end;
int ref_va_end;
int ref_hoffset;
int ref_voffset;

task automatic load_ref(input vic_pkg::chip_t c);
   case (c)
      vic_pkg::CHIP6567R8: begin
         ref_w = 519;
         ref_h = 525;
         ref_hs_sta = 10;
         ref_hs_end = 72;
         ref_ha_sta = 103;
         ref_vs_sta = 512;
         ref_vs_end = 515;
         ref_va_end = 502;
         ref_hoffset = 20;
         ref_voffset = 52;
      end
      vic_pkg::CHIP6567R56A: begin
         ref_w = 511;
         ref_h = 523;
         ref_hs_sta = 10;
         ref_hs_end = 71;
         ref_ha_sta = 102;
         ref_vs_sta = 512;
         ref_vs_end = 515;
         ref_va_end = 502;
         ref_hoffset = 20;
         ref_voffset = 52;
      end
      default: begin
         ref_w = 503;
         ref_h = 623;
         ref_hs_sta = 10;
         ref_hs_end = 70;
         ref_ha_sta = 100;
         ref_vs_sta = 580;
         ref_vs_end = 583;
         ref_va_end = 569;
         ref_hoffset = 10;
         ref_voffset = 20;
      end
   endcase
endtask

// clocks between hsync falls
function automatic int ref_h_period();
   return 2 * (ref_w + 1);
endfunction

function automatic int ref_hsync_low();
   return 2 * (ref_hs_end - ref_hs_sta);
endfunction

// clocks from hsync fall to active rise
function automatic int ref_active_delay();
   return 2 * (ref_ha_sta - ref_hs_sta);
endfunction

function automatic int ref_vsync_lines();
   return ref_vs_end - ref_vs_sta;
endfunction

function automatic int ref_frame_lines();
   return ref_h + 1;
endfunction

// lines from the realign value to the first vsync fall
function automatic int ref_first_vsync_lines();
   int m;
   m = ref_h + 1;
   return (((ref_vs_sta - (ref_h - ref_voffset)) % m) + m) % m;
endfunction

function automatic int unsigned lcg_next(input int unsigned s);
   return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
endfunction

`endif

// ==== dv/vic_vga_out_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_vga_out_tb;

   import vic_pkg::*;

   localparam int LINE_LIMIT  = 1200;
   localparam int FRAME_LIMIT = 700000;
   localparam int LINE_LEN    = 520;

   logic                  clk_dot4x;
   logic                  rst;
   chip_t                 chip;
   logic [RASTER_X_W-1:0] raster_x;
   logic [RASTER_Y_W-1:0] raster_y;
   vic_color              pixel_color3;
   logic                  hsync;
   logic                  vsync;
   logic                  active;
   vic_color              pixel_color4;

   int unsigned lcg_state;
   int          line_ref [0:LINE_LEN-1];

`include "vga_ref.svh"

   vic_vga_out #(
      .line_buf_depth (LINE_LEN)
   ) vic_vga_out_i (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .chip         (chip),
      .raster_x     (raster_x),
      .raster_y     (raster_y),
      .pixel_color3 (pixel_color3),
      .hsync        (hsync),
      .vsync        (vsync),
      .active       (active),
      .pixel_color4 (pixel_color4)
   );

   always #2 clk_dot4x = ~clk_dot4x;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         abort_run($sformatf("Mismatch at %0t: %s expected %0d got %0d",
                             $time, name, expected, actual));
      end
   endtask

   function automatic int sig_value(input int sel);
      case (sel)
         0:       return int'(hsync);
         1:       return int'(vsync);
         default: return int'(active);
      endcase
   endfunction

   // waits on falling clock edges for one edge of hsync, vsync or active
   task automatic wait_edge(input int sel, input int rising, input int limit,
                            input string what, output int clocks);
      int prev;
      int cur;
      int n;
      bit seen;
      prev = sig_value(sel);
      n = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk_dot4x);
         n = n + 1;
         cur = sig_value(sel);
         if ((rising != 0) ? (prev == 0 && cur == 1) : (prev == 1 && cur == 0)) begin
            seen = 1'b1;
         end else if (n >= limit) begin
            abort_run({"timeout: ", what, " never came"});
         end
         prev = cur;
      end
      clocks = n;
   endtask

   // counts hsync falls until vsync makes the wanted edge
   task automatic count_lines(input int vs_rising, input string what, output int lines);
      int h_prev;
      int v_prev;
      int n;
      bit seen;
      h_prev = int'(hsync);
      v_prev = int'(vsync);
      n = 0;
      lines = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk_dot4x);
         n = n + 1;
         if (h_prev == 1 && int'(hsync) == 0) begin
            lines = lines + 1;
         end
         if ((vs_rising != 0) ? (v_prev == 0 && int'(vsync) == 1)
                              : (v_prev == 1 && int'(vsync) == 0)) begin
            seen = 1'b1;
         end else if (n >= FRAME_LIMIT) begin
            abort_run({"timeout: ", what, " never came"});
         end
         h_prev = int'(hsync);
         v_prev = int'(vsync);
      end
   endtask

   task automatic check_reset_state();
      check_value("hsync", 1, int'(hsync));
      check_value("vsync", 1, int'(vsync));
      check_value("active", 0, int'(active));
      check_value("pixel_color4", int'(BLACK), int'(pixel_color4));
   endtask

   task automatic apply_reset(input chip_t c);
      @(negedge clk_dot4x);
      rst = 1'b1;
      chip = c;
      raster_x = 10'd1;
      raster_y = 9'd5;
      load_ref(c);
      for (int i = 0; i < 8; i++) begin
         @(negedge clk_dot4x);
         if (i > 0) begin
            check_reset_state();
         end
      end
      rst = 1'b0;
      @(negedge clk_dot4x);
      check_reset_state();
   endtask

   task automatic check_vertical();
      int lines;
      int low_lines;
      int rest;
      count_lines(0, "first vsync fall", lines);
      check_value("lines to first vsync", ref_first_vsync_lines(), lines);
      count_lines(1, "vsync rise", low_lines);
      check_value("vsync low lines", ref_vsync_lines(), low_lines);
      count_lines(0, "next vsync fall", rest);
      check_value("vsync period lines", ref_frame_lines(), low_lines + rest);
   endtask

   task automatic check_horizontal();
      int low;
      int rest;
      int dummy;
      wait_edge(0, 0, LINE_LIMIT, "hsync fall", dummy);
      wait_edge(0, 1, LINE_LIMIT, "hsync rise", low);
      check_value("hsync low clocks", ref_hsync_low(), low);
      wait_edge(0, 0, LINE_LIMIT, "hsync fall", rest);
      check_value("hsync period clocks", ref_h_period(), low + rest);
   endtask

   // origin dot lands right after an hsync fall and its partial line counts as one
   task automatic check_realign();
      int lines;
      raster_x = 10'd0;
      raster_y = 9'd0;
      repeat (4) @(negedge clk_dot4x);
      raster_x = 10'd1;
      raster_y = 9'd5;
      count_lines(0, "vsync fall after realign", lines);
      check_value("lines after realign", ref_first_vsync_lines(), lines + 1);
   endtask

   task automatic check_pixels();
      int dummy;
      int k;
      int first_k;
      int exp_act;
      int exp_col;
      // first active line of a frame leaves room for the whole test
      wait_edge(1, 0, FRAME_LIMIT, "vsync fall", dummy);
      wait_edge(2, 1, FRAME_LIMIT, "active rise", dummy);
      for (int x = 0; x < LINE_LEN; x++) begin
         lcg_state = lcg_next(lcg_state);
         line_ref[x] = int'((lcg_state >> 16) & 32'd15);
         raster_x = 10'(x);
         pixel_color3 = vic_color'(4'(line_ref[x]));
         repeat (4) @(negedge clk_dot4x);
      end
      // new line start swaps the banks
      raster_x = 10'd0;
      repeat (4) @(negedge clk_dot4x);
      raster_x = 10'd1;
      wait_edge(0, 0, 2 * LINE_LIMIT, "hsync fall before pixel check", dummy);
      k = 0;
      first_k = -1;
      for (int h = ref_hs_sta; h <= ref_w; h++) begin
         for (int ph = 0; ph < 2; ph++) begin
            if (k > 0) begin
               @(negedge clk_dot4x);
            end
            if (active && first_k < 0) begin
               first_k = k;
            end
            if (ph == 1) begin
               exp_act = (h >= ref_ha_sta) ? 1 : 0;
               exp_col = (exp_act == 1) ? line_ref[h - ref_hoffset] : int'(BLACK);
               check_value("active", exp_act, int'(active));
               check_value("pixel_color4", exp_col, int'(pixel_color4));
            end
            k = k + 1;
         end
      end
      check_value("active rise clocks", ref_active_delay(), first_k);
   endtask

   initial begin
      clk_dot4x = 1'b0;
      rst = 1'b1;
      chip = CHIP6569;
      raster_x = 10'd1;
      raster_y = 9'd5;
      pixel_color3 = BLACK;
      lcg_state = 32'd12;
      for (int c = 0; c < 3; c++) begin
         case (c)
            0:       apply_reset(CHIP6569);
            1:       apply_reset(CHIP6567R8);
            default: apply_reset(CHIP6567R56A);
         endcase
         check_vertical();
         check_horizontal();
         check_realign();
         check_pixels();
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the scan doubler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   -f vlog.f \
   --top-module vic_vga_out_tb \
   -Mdir obj_dir

out=$(./obj_dir/Vvic_vga_out_tb || true)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
   exit 0
else
   echo "simulation did not pass"
   exit 1
fi

// ==== source/dot_phase_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_phase_fsm (
   input  wire                            clk_dot4x,
   input  wire                            rst,
   input  wire [vic_pkg::RASTER_X_W-1:0]  raster_x,
   input  wire [vic_pkg::RASTER_Y_W-1:0]  raster_y,
   output logic                           dot_strobe,
   output logic                           line_start,
   output logic                           frame_start,
   output logic                           pixel_advance
);

   // one state per clk_dot4x tick inside a chip dot
   typedef enum logic [1:0] {
      PHASE0,
      PHASE1,
      PHASE2,
      PHASE3
   } phase_t;

   phase_t state;
   phase_t state_next;

   always_comb begin
      case (state)
         PHASE0:  state_next = PHASE1;
         PHASE1:  state_next = PHASE2;
         PHASE2:  state_next = PHASE3;
         default: state_next = PHASE0;
      endcase
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         state <= PHASE0;
      end else begin
         state <= state_next;
      end
   end

   // last tick of the dot, the chip pixel is stable here
   assign dot_strobe = (state == PHASE3);

   // vga counters step at half the tick rate
   assign pixel_advance = (state == PHASE1) || (state == PHASE3);

   // first pixel of a chip line
   assign line_start = dot_strobe && (raster_x == '0);

   // raster origin, seen on every tick of that dot
   assign frame_start = (raster_x == '0) && (raster_y == '0);

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
   parameter int line_buf_depth = 520
) (
   input  wire                             clk_dot4x,
   input  wire                             rst,
   input  wire                             dot_strobe,
   input  wire                             line_start,
   input  wire [vic_pkg::RASTER_X_W-1:0]   wr_addr,
   input  vic_pkg::vic_color               wr_color,
   input  wire [vic_pkg::COUNT_W-1:0]      rd_addr,
   output vic_pkg::vic_color               rd_color
);

   import vic_pkg::*;

   // two banks, one filling from the chip while the other is shown
   vic_color mem [0:1][0:line_buf_depth-1];

   // bank taking chip pixels for the current line
   logic wr_bank;

   // pixel 0 of a new line already lands in the next bank
   logic wr_sel;

   assign wr_sel = line_start ? ~wr_bank : wr_bank;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         wr_bank <= 1'b0;
      end else if (line_start) begin
         wr_bank <= ~wr_bank;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (dot_strobe) begin
         mem[wr_sel][wr_addr] <= wr_color;
      end
   end

   // previous chip line, read without a clock
   assign rd_color = mem[~wr_bank][rd_addr];

endmodule

`default_nettype wire

// ==== source/pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
   input  wire                          clk_dot4x,
   input  wire                          rst,
   input  wire [vic_pkg::COUNT_W-1:0]   h_count,
   input  wire [vic_pkg::COUNT_W-1:0]   hoffset,
   input  wire                          active,
   output logic [vic_pkg::COUNT_W-1:0]  rd_addr,
   input  vic_pkg::vic_color            rd_color,
   output vic_pkg::vic_color            pixel_color4
);

   import vic_pkg::*;

   // h_count has reached the first stored pixel
   logic     in_line;

   // colour fetched for the current h_count
   vic_color color_q;

   assign in_line = (h_count >= hoffset);

   // buffer column for this vga column
   assign rd_addr = in_line ? (h_count - hoffset) : '0;

   // one tick of latency, so the second tick of each column is valid
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         color_q <= BLACK;
      end else if (in_line) begin
         color_q <= rd_color;
      end else begin
         color_q <= BLACK;
      end
   end

   // black outside the drawing window
   assign pixel_color4 = active ? color_q : BLACK;

endmodule

`default_nettype wire

// ==== source/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
   input  wire                          clk_dot4x,
   input  wire                          rst,
   input  vic_pkg::chip_t               chip,
   input  wire                          pixel_advance,
   input  wire                          frame_start,
   output logic [vic_pkg::COUNT_W-1:0]  h_count,
   output logic [vic_pkg::COUNT_W-1:0]  hoffset,
   output logic                         hsync,
   output logic                         vsync,
   output logic                         active
);

   import vic_pkg::*;

   // constants for the selected chip
   chip_timing_t cfg_sel;

   // constants held for the whole run
   chip_timing_t tm;

   logic [COUNT_W-1:0] v_count;
   logic [COUNT_W-1:0] realign_v;
   logic               h_wrap;
   logic               v_wrap;

   assign cfg_sel = chip_timing(chip);

   // chip model is only sampled while in reset
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tm <= cfg_sel;
      end
   end

   // line the vga frame is forced to at the chip raster origin
   assign realign_v = tm.screen_height - tm.voffset;

   assign h_wrap = (h_count >= tm.screen_width);
   assign v_wrap = (v_count >= tm.screen_height);

   // horizontal position, each value lasts two ticks
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         h_count <= '0;
      end else if (pixel_advance) begin
         if (h_wrap) begin
            h_count <= '0;
         end else begin
            h_count <= h_count + 1'b1;
         end
      end
   end

   // vertical position, every chip line shows up twice here
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         v_count <= cfg_sel.screen_height - cfg_sel.voffset;
      end else if (frame_start) begin
         // realign wins over the normal advance
         v_count <= realign_v;
      end else if (pixel_advance && h_wrap) begin
         if (v_wrap) begin
            v_count <= '0;
         end else begin
            v_count <= v_count + 1'b1;
         end
      end
   end

   // both syncs are active low
   assign hsync = ~((h_count >= tm.hs_sta) && (h_count < tm.hs_end));
   assign vsync = ~((v_count >= tm.vs_sta) && (v_count < tm.vs_end));

   // drawing window
   assign active = (h_count >= tm.ha_sta) && (v_count < tm.va_end);

   // pixel 0 of the buffer lines up with this column
   assign hoffset = tm.hoffset;

endmodule

`default_nettype wire

// ==== source/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

   // chip raster position widths
   localparam int RASTER_X_W = 10;
   localparam int RASTER_Y_W = 9;

   // width of the vga side counters and of every timing value
   localparam int COUNT_W = 10;

   // vic-ii palette index
   typedef enum logic [3:0] {
      BLACK,
      WHITE,
      RED,
      CYAN,
      PURPLE,
      GREEN,
      BLUE,
      YELLOW,
      ORANGE,
      BROWN,
      PINK,
      DARK_GREY,
      GREY,
      LIGHT_GREEN,
      LIGHT_BLUE,
      LIGHT_GREY
   } vic_color;

   typedef enum logic [1:0] {
      CHIP6567R56A,
      CHIP6567R8,
      CHIP6569,
      CHIPUNUSED
   } chip_t;

   typedef struct packed {
      logic [COUNT_W-1:0] screen_width;
      logic [COUNT_W-1:0] screen_height;
      logic [COUNT_W-1:0] hs_sta;
      logic [COUNT_W-1:0] hs_end;
      logic [COUNT_W-1:0] ha_sta;
      logic [COUNT_W-1:0] vs_sta;
      logic [COUNT_W-1:0] vs_end;
      logic [COUNT_W-1:0] va_end;
      logic [COUNT_W-1:0] hoffset;
      logic [COUNT_W-1:0] voffset;
   } chip_timing_t;

   // per-chip raster geometry, the unused code runs as a pal part
   function automatic chip_timing_t chip_timing(input chip_t chip);
      chip_timing_t t;
      case (chip)
         CHIP6567R8: begin
            t = '{screen_width: 10'd519, screen_height: 10'd525,
                  hs_sta: 10'd10, hs_end: 10'd72, ha_sta: 10'd103,
                  vs_sta: 10'd512, vs_end: 10'd515, va_end: 10'd502,
                  hoffset: 10'd20, voffset: 10'd52};
         end
         CHIP6567R56A: begin
            t = '{screen_width: 10'd511, screen_height: 10'd523,
                  hs_sta: 10'd10, hs_end: 10'd71, ha_sta: 10'd102,
                  vs_sta: 10'd512, vs_end: 10'd515, va_end: 10'd502,
                  hoffset: 10'd20, voffset: 10'd52};
         end
         default: begin
            t = '{screen_width: 10'd503, screen_height: 10'd623,
                  hs_sta: 10'd10, hs_end: 10'd70, ha_sta: 10'd100,
                  vs_sta: 10'd580, vs_end: 10'd583, va_end: 10'd569,
                  hoffset: 10'd10, voffset: 10'd20};
         end
      endcase
      return t;
   endfunction

endpackage

`default_nettype wire

// ==== source/vic_vga_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_vga_out #(
   parameter int line_buf_depth = 520
) (
   input  wire                             clk_dot4x,
   input  wire                             rst,
   input  vic_pkg::chip_t                  chip,
   input  wire [vic_pkg::RASTER_X_W-1:0]   raster_x,
   input  wire [vic_pkg::RASTER_Y_W-1:0]   raster_y,
   input  vic_pkg::vic_color               pixel_color3,
   output logic                            hsync,
   output logic                            vsync,
   output logic                            active,
   output vic_pkg::vic_color               pixel_color4
);

   import vic_pkg::*;

   logic               dot_strobe;
   logic               line_start;
   logic               frame_start;
   logic               pixel_advance;
   logic [COUNT_W-1:0] h_count;
   logic [COUNT_W-1:0] hoffset;
   logic [COUNT_W-1:0] rd_addr;
   vic_color           rd_color;

   dot_phase_fsm u_phase (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .raster_x      (raster_x),
      .raster_y      (raster_y),
      .dot_strobe    (dot_strobe),
      .line_start    (line_start),
      .frame_start   (frame_start),
      .pixel_advance (pixel_advance)
   );

   vga_timing u_timing (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .chip          (chip),
      .pixel_advance (pixel_advance),
      .frame_start   (frame_start),
      .h_count       (h_count),
      .hoffset       (hoffset),
      .hsync         (hsync),
      .vsync         (vsync),
      .active        (active)
   );

   // chip raster_x doubles as the write column
   line_buffer #(
      .line_buf_depth (line_buf_depth)
   ) u_line_buf (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .dot_strobe (dot_strobe),
      .line_start (line_start),
      .wr_addr    (raster_x),
      .wr_color   (pixel_color3),
      .rd_addr    (rd_addr),
      .rd_color   (rd_color)
   );

   pixel_out u_pixel (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .h_count      (h_count),
      .hoffset      (hoffset),
      .active       (active),
      .rd_addr      (rd_addr),
      .rd_color     (rd_color),
      .pixel_color4 (pixel_color4)
   );

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
source/vic_pkg.sv
source/dot_phase_fsm.sv
source/vga_timing.sv
source/line_buffer.sv
source/pixel_out.sv
source/vic_vga_out.sv
dv/vic_vga_out_tb.sv
